// ==== verilog/cia_defines.svh ====
// Register offsets of the CIA bus map
// Reset values for the timer latches and the TOD hour register

`ifndef CIA_DEFINES_SVH
`define CIA_DEFINES_SVH

`define CIA_REG_PRA     4'h0
`define CIA_REG_PRB     4'h1
`define CIA_REG_DDRA    4'h2
`define CIA_REG_DDRB    4'h3
`define CIA_REG_TALO    4'h4
`define CIA_REG_TAHI    4'h5
`define CIA_REG_TBLO    4'h6
`define CIA_REG_TBHI    4'h7
`define CIA_REG_TOD10   4'h8
`define CIA_REG_TODSEC  4'h9
`define CIA_REG_TODMIN  4'hA
`define CIA_REG_TODHR   4'hB
`define CIA_REG_SDR     4'hC
`define CIA_REG_ICR     4'hD
`define CIA_REG_CRA     4'hE
`define CIA_REG_CRB     4'hF

`define CIA_TIMER_RESET_LATCH 16'hFFFF
// {pm, hr} = 01 AM
`define CIA_TOD_RESET_HR      6'h01

`endif

// ==== verilog/cia_reg_pkg.sv ====
// Register map types
// Register offset enum, timer control fields, TOD time fields

`default_nettype none

`include "cia_defines.svh"

package cia_reg_pkg;

  typedef enum logic [3:0] {
    REG_PRA       = `CIA_REG_PRA,
    REG_PRB       = `CIA_REG_PRB,
    REG_DDRA      = `CIA_REG_DDRA,
    REG_DDRB      = `CIA_REG_DDRB,
    REG_TA_LO     = `CIA_REG_TALO,
    REG_TA_HI     = `CIA_REG_TAHI,
    REG_TB_LO     = `CIA_REG_TBLO,
    REG_TB_HI     = `CIA_REG_TBHI,
    REG_TOD_10THS = `CIA_REG_TOD10,
    REG_TOD_SEC   = `CIA_REG_TODSEC,
    REG_TOD_MIN   = `CIA_REG_TODMIN,
    REG_TOD_HR    = `CIA_REG_TODHR,
    REG_SDR       = `CIA_REG_SDR,
    REG_ICR       = `CIA_REG_ICR,
    REG_CRA       = `CIA_REG_CRA,
    REG_CRB       = `CIA_REG_CRB
  } reg_addr_t;

  typedef struct packed {
    // tod_50hz on Timer A, alarm_sel on Timer B
    logic       tod_sel;
    // Timer B source, 00 phi2, 10 Timer A underflow
    logic [1:0] in_mode;
    logic       force_load;
    logic       one_shot;
    // Set for toggle output
    logic       out_mode;
    logic       pb_on;
    logic       start;
  } timer_ctrl_t;

  typedef struct packed {
    logic       pm;
    logic [4:0] hr;
    logic [6:0] min;
    logic [6:0] sec;
    logic [3:0] tenths;
  } tod_time_t;

endpackage

`default_nettype wire

// ==== verilog/cia_irq_pkg.sv ====
// Interrupt source types
// Source index enum and one-bit-per-source vector

`default_nettype none

package cia_irq_pkg;

  localparam int IRQ_NUM_SRC = 5;

  typedef enum logic [2:0] {
    IRQ_TA    = 3'd0,
    IRQ_TB    = 3'd1,
    IRQ_ALARM = 3'd2,
    IRQ_SP    = 3'd3,
    IRQ_FLAG  = 3'd4
  } irq_src_e;

  typedef logic [IRQ_NUM_SRC-1:0] irq_vec_t;

endpackage

`default_nettype wire

// ==== verilog/cia_io_ports.sv ====
// Port A and B data and direction registers
// PB6/PB7 timer output overlay and PC handshake pulse

`default_nettype none

module cia_io_ports import cia_reg_pkg::*; (
  input  logic        clk,
  input  logic        int_reset,
  input  logic        phi2,
  input  logic        wr_stb,
  input  logic        rd_stb,
  input  logic [3:0]  rs,
  input  logic [7:0]  db_in,
  input  logic        ta_underflow,
  input  logic        tb_underflow,
  input  logic        ta_toggle,
  input  logic        tb_toggle,
  input  timer_ctrl_t ta_ctrl,
  input  timer_ctrl_t tb_ctrl,
  output logic [7:0]  pa_out,
  output logic [7:0]  pb_out,
  output logic        pc_n,
  output logic [7:0]  ddra,
  output logic [7:0]  ddrb
);

  logic [7:0] pra;
  logic [7:0] prb;
  logic       pb6_timer;
  logic       pb7_timer;

  // Toggle flip-flop flips at the same edge as the underflow
  assign pb6_timer = ta_ctrl.out_mode ? (ta_toggle ^ ta_underflow) : ta_underflow;
  assign pb7_timer = tb_ctrl.out_mode ? (tb_toggle ^ tb_underflow) : tb_underflow;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pra  <= 8'h00;
      prb  <= 8'h00;
      ddra <= 8'h00;
      ddrb <= 8'h00;
    end else if (wr_stb) begin
      case (reg_addr_t'(rs))
        REG_PRA:  pra  <= db_in;
        REG_PRB:  prb  <= db_in;
        REG_DDRA: ddra <= db_in;
        REG_DDRB: ddrb <= db_in;
        default: ;
      endcase
    end
  end

  // Inputs float high, so undriven pins read as ones
  always_ff @(posedge clk) begin
    if (int_reset) begin
      pa_out <= 8'hFF;
      pb_out <= 8'hFF;
      pc_n   <= 1'b1;
    end else begin
      if (phi2) begin
        pa_out      <= pra | ~ddra;
        pb_out[5:0] <= prb[5:0] | ~ddrb[5:0];
        pb_out[6]   <= ta_ctrl.pb_on ? pb6_timer : (prb[6] | ~ddrb[6]);
        pb_out[7]   <= tb_ctrl.pb_on ? pb7_timer : (prb[7] | ~ddrb[7]);
      end
      if ((wr_stb || rd_stb) && rs == REG_PRB) begin
        pc_n <= 1'b0;
      end else if (phi2) begin
        pc_n <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cia_interval_timer.sv ====
// 16-bit interval timer
// Latch, control register, two-stage count pipeline and toggle flip-flop

`default_nettype none

`include "cia_defines.svh"

module cia_interval_timer import cia_reg_pkg::*; (
  input  logic        clk,
  input  logic        int_reset,
  input  logic        phi2,
  input  logic        count_en,
  input  logic        wr_stb,
  input  logic [3:0]  rs,
  input  logic [7:0]  db_in,
  input  reg_addr_t   lo_addr,
  input  reg_addr_t   hi_addr,
  input  reg_addr_t   ctrl_addr,
  output logic [15:0] count,
  output timer_ctrl_t ctrl,
  output logic        toggle,
  output logic        underflow
);

  logic [15:0] latch;
  logic [15:0] next_count;
  // Count pulses in flight
  logic        cnt_stage2;
  logic        cnt_stage3;
  logic        load_pend;
  logic        one_shot_q;

  assign next_count = cnt_stage3 ? count - 16'd1 : count;

  // Count about to reach zero
  assign underflow = phi2 & cnt_stage2 & (next_count == 16'h0000);

  always_ff @(posedge clk) begin
    if (int_reset) begin
      latch      <= `CIA_TIMER_RESET_LATCH;
      count      <= 16'h0000;
      ctrl       <= '0;
      toggle     <= 1'b0;
      cnt_stage2 <= 1'b0;
      cnt_stage3 <= 1'b0;
      load_pend  <= 1'b0;
      one_shot_q <= 1'b0;
    end else begin
      if (phi2) begin
        cnt_stage2      <= count_en & ctrl.start;
        cnt_stage3      <= cnt_stage2;
        load_pend       <= ctrl.force_load;
        ctrl.force_load <= 1'b0;
        one_shot_q      <= ctrl.one_shot;
        count           <= next_count;

        if (underflow) begin
          toggle     <= ~toggle;
          count      <= latch;
          cnt_stage3 <= 1'b0;
          // One-shot stops itself and drops the pending pulse
          if (ctrl.one_shot || one_shot_q) begin
            ctrl.start <= 1'b0;
            cnt_stage2 <= 1'b0;
          end
        end

        if (load_pend) begin
          count      <= latch;
          cnt_stage3 <= 1'b0;
        end
      end

      if (wr_stb) begin
        if (rs == lo_addr) begin
          latch[7:0] <= db_in;
        end
        if (rs == hi_addr) begin
          latch[15:8] <= db_in;
          // Stopped timer loads straight from the bus
          if (!ctrl.start) begin
            count      <= {db_in, latch[7:0]};
            cnt_stage3 <= 1'b0;
          end
        end
        if (rs == ctrl_addr) begin
          ctrl   <= timer_ctrl_t'(db_in);
          // Output starts high when the timer is started
          toggle <= toggle | (db_in[0] & ~ctrl.start);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cia_tod_clock.sv ====
// BCD time-of-day clock
// 50/60 Hz prescaler, 12-hour rollover, read latch, alarm match

`default_nettype none

`include "cia_defines.svh"

module cia_tod_clock import cia_reg_pkg::*; (
  input  logic       clk,
  input  logic       int_reset,
  input  logic       phi2,
  input  logic       tod,
  input  logic       tod_50hz,
  input  logic       alarm_sel,
  input  logic       wr_stb,
  input  logic       rd_stb,
  input  logic [3:0] rs,
  input  logic [7:0] db_in,
  output logic [7:0] tod_rd_data,
  output logic       alarm_hit
);

  tod_time_t  cur;
  tod_time_t  alarm;
  tod_time_t  rd_latch;
  logic       run;
  logic       latched;
  logic       tod_prev;
  logic       tod_rise;
  logic [2:0] presc;
  logic       tick;
  logic       match;
  logic       match_q;
  logic       rd_hr;

  // Returns {carry, next} for a 00..59 BCD field
  function automatic logic [7:0] bcd60_inc(input logic [6:0] v);
    logic [7:0] r;
    if (v == 7'h59) begin
      r = 8'h80;
    end else if (v[3:0] == 4'h9) begin
      r = {1'b0, v[6:4] + 3'd1, 4'h0};
    end else begin
      r = {1'b0, v[6:4], v[3:0] + 4'd1};
    end
    return r;
  endfunction

  function automatic tod_time_t tod_next(input tod_time_t t);
    tod_time_t  n;
    logic [7:0] s;
    logic [7:0] m;
    n = t;
    s = bcd60_inc(t.sec);
    m = bcd60_inc(t.min);
    if (t.tenths != 4'h9) begin
      n.tenths = t.tenths + 4'd1;
    end else begin
      n.tenths = 4'h0;
      n.sec    = s[6:0];
      if (s[7]) begin
        n.min = m[6:0];
        if (m[7]) begin
          // 11 -> 12 flips AM/PM, 12 -> 1 does not
          if (t.hr == 5'h11) begin
            n.hr = 5'h12;
            n.pm = ~t.pm;
          end else if (t.hr == 5'h12) begin
            n.hr = 5'h01;
          end else if (t.hr[3:0] == 4'h9) begin
            n.hr = 5'h10;
          end else begin
            n.hr = {t.hr[4], t.hr[3:0] + 4'd1};
          end
        end
      end
    end
    return n;
  endfunction

  assign tod_rise  = tod & ~tod_prev;
  assign rd_hr     = rd_stb && (rs == REG_TOD_HR);
  assign match     = (cur == alarm);
  assign alarm_hit = phi2 & match & ~match_q;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      cur      <= tod_time_t'({`CIA_TOD_RESET_HR, 18'h00000});
      alarm    <= '0;
      run      <= 1'b0;
      latched  <= 1'b0;
      tod_prev <= 1'b0;
      presc    <= 3'd0;
      tick     <= 1'b0;
      match_q  <= 1'b0;
    end else begin
      tod_prev <= tod;
      tick     <= 1'b0;
      if (!run) begin
        presc <= 3'd0;
      end else if (tod_rise) begin
        if (presc == (tod_50hz ? 3'd4 : 3'd5)) begin
          presc <= 3'd0;
          tick  <= 1'b1;
        end else begin
          presc <= presc + 3'd1;
        end
      end
      if (tick && run) begin
        cur <= tod_next(cur);
      end
      if (phi2) begin
        match_q <= match;
      end

      // Hours read freezes the latch, tenths read releases it
      if (rd_stb && rs == REG_TOD_10THS) begin
        latched <= 1'b0;
      end else if (rd_hr) begin
        latched <= 1'b1;
      end

      if (wr_stb) begin
        case (reg_addr_t'(rs))
          REG_TOD_10THS: begin
            if (alarm_sel) begin
              alarm.tenths <= db_in[3:0];
            end else begin
              cur.tenths <= db_in[3:0];
              run        <= 1'b1;
            end
          end
          REG_TOD_SEC: begin
            if (alarm_sel) alarm.sec <= db_in[6:0];
            else cur.sec <= db_in[6:0];
          end
          REG_TOD_MIN: begin
            if (alarm_sel) alarm.min <= db_in[6:0];
            else cur.min <= db_in[6:0];
          end
          REG_TOD_HR: begin
            if (alarm_sel) begin
              {alarm.pm, alarm.hr} <= {db_in[7], db_in[4:0]};
            end else begin
              {cur.pm, cur.hr} <= {db_in[7], db_in[4:0]};
              run              <= 1'b0;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (phi2 && !latched && !rd_hr) begin
      rd_latch <= cur;
    end
  end

  always_comb begin
    case (reg_addr_t'(rs))
      REG_TOD_10THS: tod_rd_data = {4'h0, rd_latch.tenths};
      REG_TOD_SEC:   tod_rd_data = {1'b0, rd_latch.sec};
      REG_TOD_MIN:   tod_rd_data = {1'b0, rd_latch.min};
      REG_TOD_HR:    tod_rd_data = {rd_latch.pm, 2'b00, rd_latch.hr};
      default:       tod_rd_data = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/cia_irq_ctrl.sv ====
// Interrupt control register
// Flag capture, set/clear mask, irq_n and clear-on-read

`default_nettype none

module cia_irq_ctrl import cia_reg_pkg::*; import cia_irq_pkg::*; (
  input  logic       clk,
  input  logic       int_reset,
  input  logic       phi2,
  input  logic       wr_stb,
  input  logic       rd_stb,
  input  logic [3:0] rs,
  input  logic [7:0] db_in,
  input  logic       flag_n,
  input  irq_vec_t   src_set,
  output logic [7:0] icr_rd_data,
  output logic       irq_n
);

  irq_vec_t   flags;
  irq_vec_t   mask;
  irq_vec_t   set_vec;
  logic [7:0] mask_wr;
  logic       flag_prev;
  logic       icr_clear;

  always_comb begin
    set_vec           = src_set;
    set_vec[IRQ_FLAG] = src_set[IRQ_FLAG] | (phi2 & ~flag_n & flag_prev);
  end

  assign icr_rd_data = {~irq_n, 2'b00, flags};

  always_ff @(posedge clk) begin
    if (int_reset) begin
      flags     <= '0;
      mask      <= '0;
      mask_wr   <= 8'h00;
      flag_prev <= 1'b1;
      icr_clear <= 1'b0;
      irq_n     <= 1'b1;
    end else begin
      icr_clear <= rd_stb && (rs == REG_ICR);
      if (wr_stb && rs == REG_ICR) begin
        mask_wr <= db_in;
      end
      flags <= flags | set_vec;
      if (phi2) begin
        flag_prev <= flag_n;
        // Bit 7 picks set or clear for the selected mask bits
        mask  <= mask_wr[7] ? (mask | mask_wr[4:0]) : (mask & ~mask_wr[4:0]);
        irq_n <= irq_n ? ~|(mask & flags) : irq_n;
      end
      // Sources firing in the clear cycle survive
      if (phi2 && icr_clear) begin
        flags <= set_vec;
        irq_n <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cia_core.sv ====
// CIA top level
// Bus strobes, Timer B source select, interrupt sources, read data mux

`default_nettype none

module cia_core import cia_reg_pkg::*; import cia_irq_pkg::*; (
  input  logic       clk,
  input  logic       int_reset,
  input  logic       phi2,
  input  logic       cs_n,
  input  logic       rw,
  input  logic [3:0] rs,
  input  logic [7:0] db_in,
  output logic [7:0] db_out,
  input  logic [7:0] pa_in,
  output logic [7:0] pa_out,
  input  logic [7:0] pb_in,
  output logic [7:0] pb_out,
  input  logic       flag_n,
  output logic       pc_n,
  input  logic       tod,
  output logic       irq_n
);

  logic        wr_stb;
  logic        rd_stb;
  logic [7:0]  ddra;
  logic [7:0]  ddrb;
  logic [15:0] ta_count;
  logic [15:0] tb_count;
  timer_ctrl_t ta_ctrl;
  timer_ctrl_t tb_ctrl;
  logic        ta_toggle;
  logic        tb_toggle;
  logic        ta_underflow;
  logic        tb_underflow;
  logic        tb_count_en;
  logic [7:0]  tod_rd_data;
  logic        alarm_hit;
  logic [7:0]  icr_rd_data;
  irq_vec_t    src_set;

  // Force-load is a strobe and reads back as zero
  function automatic logic [7:0] ctrl_rd(input timer_ctrl_t c);
    timer_ctrl_t r;
    r            = c;
    r.force_load = 1'b0;
    return r;
  endfunction

  assign wr_stb = ~cs_n & ~rw;
  assign rd_stb = ~cs_n & rw;

  // No CNT pin, so the CNT modes never count
  always_comb begin
    case (tb_ctrl.in_mode)
      2'b00:   tb_count_en = phi2;
      2'b10:   tb_count_en = ta_underflow;
      default: tb_count_en = 1'b0;
    endcase
  end

  always_comb begin
    src_set            = '0;
    src_set[IRQ_TA]    = ta_underflow;
    src_set[IRQ_TB]    = tb_underflow;
    src_set[IRQ_ALARM] = alarm_hit;
    // No serial port
    src_set[IRQ_SP]    = 1'b0;
  end

  cia_io_ports io_ports_i (
    .clk, .int_reset, .phi2, .wr_stb, .rd_stb, .rs, .db_in,
    .ta_underflow, .tb_underflow, .ta_toggle, .tb_toggle, .ta_ctrl, .tb_ctrl,
    .pa_out, .pb_out, .pc_n, .ddra, .ddrb
  );

  cia_interval_timer timer_a_i (
    .clk, .int_reset, .phi2, .count_en(phi2), .wr_stb, .rs, .db_in,
    .lo_addr(REG_TA_LO), .hi_addr(REG_TA_HI), .ctrl_addr(REG_CRA),
    .count(ta_count), .ctrl(ta_ctrl), .toggle(ta_toggle), .underflow(ta_underflow)
  );

  cia_interval_timer timer_b_i (
    .clk, .int_reset, .phi2, .count_en(tb_count_en), .wr_stb, .rs, .db_in,
    .lo_addr(REG_TB_LO), .hi_addr(REG_TB_HI), .ctrl_addr(REG_CRB),
    .count(tb_count), .ctrl(tb_ctrl), .toggle(tb_toggle), .underflow(tb_underflow)
  );

  cia_tod_clock tod_clock_i (
    .clk, .int_reset, .phi2, .tod,
    .tod_50hz(ta_ctrl.tod_sel), .alarm_sel(tb_ctrl.tod_sel),
    .wr_stb, .rd_stb, .rs, .db_in, .tod_rd_data, .alarm_hit
  );

  cia_irq_ctrl irq_ctrl_i (
    .clk, .int_reset, .phi2, .wr_stb, .rd_stb, .rs, .db_in,
    .flag_n, .src_set, .icr_rd_data, .irq_n
  );

  always_ff @(posedge clk) begin
    if (int_reset) begin
      db_out <= 8'h00;
    end else if (rd_stb) begin
      case (reg_addr_t'(rs))
        REG_PRA:       db_out <= pa_in;
        REG_PRB:       db_out <= pb_in;
        REG_DDRA:      db_out <= ddra;
        REG_DDRB:      db_out <= ddrb;
        REG_TA_LO:     db_out <= ta_count[7:0];
        REG_TA_HI:     db_out <= ta_count[15:8];
        REG_TB_LO:     db_out <= tb_count[7:0];
        REG_TB_HI:     db_out <= tb_count[15:8];
        REG_TOD_10THS: db_out <= tod_rd_data;
        REG_TOD_SEC:   db_out <= tod_rd_data;
        REG_TOD_MIN:   db_out <= tod_rd_data;
        REG_TOD_HR:    db_out <= tod_rd_data;
        REG_SDR:       db_out <= 8'h00;
        REG_ICR:       db_out <= icr_rd_data;
        REG_CRA:       db_out <= ctrl_rd(ta_ctrl);
        REG_CRB:       db_out <= ctrl_rd(tb_ctrl);
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== testbench/cia_checker.sv ====
// Concurrent checks on the interrupt controller and port A outputs
// Bound into cia_irq_ctrl and cia_io_ports

`default_nettype none

module cia_checker import cia_irq_pkg::*; #(
  parameter bit IRQ_CHECKS  = 1'b1,
  parameter bit PORT_CHECKS = 1'b1
) (
  input logic       clk,
  input logic       int_reset,
  input logic       phi2,
  input logic       irq_n,
  input logic       icr_clear,
  input irq_vec_t   mask,
  input irq_vec_t   flags,
  input logic [7:0] pra,
  input logic [7:0] ddra,
  input logic [7:0] pa_out
);

  int fail_count;

  initial fail_count = 0;

  if (IRQ_CHECKS) begin : irq_checks
    irq_high_after_reset: assert property (@(posedge clk) int_reset |=> irq_n)
      else begin
        $error("irq_n not high after reset");
        fail_count++;
      end

    // irq_n only falls from a flag that was set and unmasked
    irq_fall_needs_flag: assert property (@(posedge clk) disable iff (int_reset)
      $fell(irq_n) |-> $past(|(mask & flags)))
      else begin
        $error("irq_n fell without a masked flag");
        fail_count++;
      end

    irq_high_after_clear: assert property (@(posedge clk) disable iff (int_reset)
      (icr_clear && phi2) |=> irq_n)
      else begin
        $error("irq_n still low after the ICR read");
        fail_count++;
      end
  end

  if (PORT_CHECKS) begin : port_checks
    pa_pins_follow_regs: assert property (@(posedge clk) disable iff (int_reset)
      phi2 |=> (pa_out == $past(pra | ~ddra)))
      else begin
        $error("pa_out differs from data and direction");
        fail_count++;
      end
  end

endmodule

// Each instance runs only the checks of the block it sits in
bind cia_irq_ctrl cia_checker #(.PORT_CHECKS(1'b0)) irq_checker_i (
  .clk, .int_reset, .phi2, .irq_n, .icr_clear, .mask, .flags,
  .pra(8'h00), .ddra(8'h00), .pa_out(8'h00)
);

bind cia_io_ports cia_checker #(.IRQ_CHECKS(1'b0)) port_checker_i (
  .clk, .int_reset, .phi2, .irq_n(1'b1), .icr_clear(1'b0), .mask('0), .flags('0),
  .pra, .ddra, .pa_out
);

`default_nettype wire

// ==== testbench/cia_tb.sv ====
// Testbench for the CIA core
// Bus tasks, port, timer, interrupt and TOD tests, closing report

`default_nettype none

`include "cia_defines.svh"

module cia_tb;

  localparam int TIMEOUT = 2000;
  localparam logic [7:0] TB_LATCH = 8'd3;

  logic        clk;
  logic        int_reset;
  logic        phi2;
  logic        cs_n;
  logic        rw;
  logic [3:0]  rs;
  logic [7:0]  db_in;
  logic [7:0]  db_out;
  logic [7:0]  pa_in;
  logic [7:0]  pa_out;
  logic [7:0]  pb_in;
  logic [7:0]  pb_out;
  logic        flag_n;
  logic        pc_n;
  logic        tod;
  logic        irq_n;

  logic [31:0] rand_state;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;

  cia_core cia_core_i (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      test_errs++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    test_errs++;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
    @(posedge clk);
    #1;
    cs_n  = 1'b0;
    rw    = 1'b0;
    rs    = addr;
    db_in = data;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    rw   = 1'b1;
  endtask

  // db_out is registered, so it is valid right after the strobe edge
  task automatic read_reg(input logic [3:0] addr, output logic [7:0] data);
    @(posedge clk);
    #1;
    cs_n = 1'b0;
    rw   = 1'b1;
    rs   = addr;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    data = db_out;
  endtask

  task automatic wait_irq(input logic level, input string what);
    int n;
    n = 0;
    while (irq_n !== level && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (irq_n === level) else report_failure({what, ": irq_n never reached its level"});
  endtask

  task automatic end_test(input string name);
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  initial begin
    logic [7:0] rd;
    logic [7:0] data;
    logic [7:0] dir;
    logic [7:0] expected;
    logic [7:0] edges;
    logic       pb6_prev;
    int         n;
    int         chk_fails;

    clk        = 1'b0;
    int_reset  = 1'b1;
    phi2       = 1'b1;
    cs_n       = 1'b1;
    rw         = 1'b1;
    rs         = 4'h0;
    db_in      = 8'h00;
    pa_in      = 8'h00;
    pb_in      = 8'h00;
    flag_n     = 1'b1;
    tod        = 1'b0;
    rand_state = 32'h68a9;
    test_errs  = 0;
    total_errs = 0;
    tests_run  = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    #1;
    int_reset = 1'b0;

    // Ports
    for (int i = 0; i < 8; i++) begin
      rand_state = xorshift32(rand_state);
      data       = rand_state[7:0];
      dir        = rand_state[15:8];
      expected   = data | ~dir;
      write_reg(`CIA_REG_PRA, data);
      write_reg(`CIA_REG_DDRA, dir);
      @(posedge clk);
      #1;
      check_value("ports pa_out", expected, pa_out);
    end
    pa_in = rand_state[23:16];
    pb_in = rand_state[31:24];
    read_reg(`CIA_REG_PRA, rd);
    check_value("ports pa_in read", pa_in, rd);
    read_reg(`CIA_REG_PRB, rd);
    check_value("ports pb_in read", pb_in, rd);
    check_value("ports pc_n low", 8'h00, {7'h00, pc_n});
    n = 0;
    while (pc_n !== 1'b1 && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (pc_n === 1'b1) else report_failure("ports: pc_n stayed low after the port B read");
    end_test("ports");

    // One-shot Timer A with TA interrupt
    write_reg(`CIA_REG_TALO, 8'd20);
    write_reg(`CIA_REG_TAHI, 8'd0);
    write_reg(`CIA_REG_ICR, 8'h81);
    write_reg(`CIA_REG_CRA, 8'h09);
    wait_irq(1'b0, "one-shot");
    read_reg(`CIA_REG_ICR, rd);
    check_value("one-shot icr", 8'h81, rd);
    wait_irq(1'b1, "one-shot");
    read_reg(`CIA_REG_CRA, rd);
    check_value("one-shot cra", 8'h08, rd);
    end_test("one-shot");

    // Timer B counts Timer A underflows, PB6 toggles on each one
    write_reg(`CIA_REG_TALO, 8'd7);
    write_reg(`CIA_REG_TAHI, 8'd0);
    write_reg(`CIA_REG_TBLO, TB_LATCH);
    write_reg(`CIA_REG_TBHI, 8'd0);
    write_reg(`CIA_REG_ICR, 8'h01);
    write_reg(`CIA_REG_ICR, 8'h82);
    write_reg(`CIA_REG_CRB, 8'h41);
    pb6_prev = pb_out[6];
    edges    = 8'd0;
    write_reg(`CIA_REG_CRA, 8'h07);
    n = 0;
    while (irq_n && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      if (pb_out[6] !== pb6_prev) edges++;
      pb6_prev = pb_out[6];
      n++;
    end
    assert (!irq_n) else report_failure("cascade: Timer B never raised its interrupt");
    check_value("cascade pb6 edges", TB_LATCH + 8'd1, edges);
    write_reg(`CIA_REG_CRA, 8'h00);
    write_reg(`CIA_REG_CRB, 8'h00);
    write_reg(`CIA_REG_ICR, 8'h1F);
    read_reg(`CIA_REG_ICR, rd);
    wait_irq(1'b1, "cascade");
    end_test("cascade");

    // FLAG with the mask clear, then set
    flag_n = 1'b0;
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #1;
      check_value("mask irq_n high", 8'h01, {7'h00, irq_n});
    end
    read_reg(`CIA_REG_ICR, rd);
    check_value("mask icr unmasked", 8'h10, rd);
    flag_n = 1'b1;
    write_reg(`CIA_REG_ICR, 8'h90);
    flag_n = 1'b0;
    wait_irq(1'b0, "mask");
    read_reg(`CIA_REG_ICR, rd);
    check_value("mask icr masked", 8'h90, rd);
    flag_n = 1'b1;
    write_reg(`CIA_REG_ICR, 8'h10);
    end_test("mask");

    // TOD rollover from 11:59:59.9 AM into the alarm at 12 PM
    write_reg(`CIA_REG_CRB, 8'h80);
    write_reg(`CIA_REG_TODHR, 8'h92);
    write_reg(`CIA_REG_TODMIN, 8'h00);
    write_reg(`CIA_REG_TODSEC, 8'h00);
    write_reg(`CIA_REG_TOD10, 8'h00);
    write_reg(`CIA_REG_CRB, 8'h00);
    write_reg(`CIA_REG_TODHR, 8'h11);
    write_reg(`CIA_REG_TODMIN, 8'h59);
    write_reg(`CIA_REG_TODSEC, 8'h59);
    write_reg(`CIA_REG_TOD10, 8'h09);
    write_reg(`CIA_REG_ICR, 8'h84);
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      #1;
      tod = 1'b1;
      @(posedge clk);
      @(posedge clk);
      #1;
      tod = 1'b0;
    end
    wait_irq(1'b0, "tod");
    read_reg(`CIA_REG_TODHR, rd);
    check_value("tod hours", 8'h92, rd);
    read_reg(`CIA_REG_TODMIN, rd);
    check_value("tod minutes", 8'h00, rd);
    read_reg(`CIA_REG_TODSEC, rd);
    check_value("tod seconds", 8'h00, rd);
    read_reg(`CIA_REG_TOD10, rd);
    check_value("tod tenths", 8'h00, rd);
    read_reg(`CIA_REG_ICR, rd);
    check_value("tod icr", 8'h84, rd);
    end_test("tod");

    chk_fails = cia_core_i.irq_ctrl_i.irq_checker_i.fail_count
              + cia_core_i.io_ports_i.port_checker_i.fail_count;
    $display("tests run %0d, tests failed %0d, checks failed %0d, assertion failures %0d",
             tests_run, tests_failed, total_errs, chk_fails);
    if (total_errs == 0 && chk_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/cia_reg_pkg.sv
verilog/cia_irq_pkg.sv
verilog/cia_io_ports.sv
verilog/cia_interval_timer.sv
verilog/cia_tod_clock.sv
verilog/cia_irq_ctrl.sv
verilog/cia_core.sv
testbench/cia_checker.sv
testbench/cia_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CIA testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cia_tb -f compile.f
./obj_dir/Vcia_tb +verilator+error+limit+1000 | tee sim.log
if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
